// ==== Bender.yml ====
package:
  name: sdram_ctrl

sources:
  - rtl/sdramGeomPkg.sv
  - rtl/sdramCmdPkg.sv
  - rtl/burstFifo.sv
  - rtl/burstArbiter.sv
  - rtl/burstSequencer.sv
  - rtl/sdramPinStage.sv
  - rtl/sdramCtrlTop.sv
  - target: simulation
    files:
      - dv/sdramModel.sv
      - dv/sdramCtrlTb.sv

// ==== dv/sdramCtrlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdramCtrlTb import sdramGeomPkg::*, sdramCmdPkg::*;
;

	localparam int WAIT_LIMIT   = 5000;
	localparam int QUIET_CYCLES = 24;                       // Covers refresh plus read drain
	localparam int REF_LIMIT    = REFRESH_INTERVAL + 40;

	logic              REF_CLK;
	logic              RESET_N;
	logic              wrPush;
	dataWord_t         wrData;
	logic              wrFull;
	logic              wrEmpty;
	logic              wrLoad;
	memAddr_t          wrMinAddr;
	memAddr_t          wrMaxAddr;
	logic              rdPop;
	dataWord_t         rdData;
	logic              rdEmpty;
	logic              rdLoad;
	memAddr_t          rdMinAddr;
	memAddr_t          rdMaxAddr;
	logic              rdEnable;
	logic              initDone;
	pinAddr_t          sdramAddr;
	logic [BANK_W-1:0] sdramBank;
	logic              csN;
	logic              rasN;
	logic              casN;
	logic              weN;
	logic              cke;
	logic [DQM_W-1:0]  dqm;
	wire dataWord_t    dq;

	sdramCmd_e         pinCmd;
	integer            seed = 32'hdb3c;
	int                errorCount = 0;
	int                testCount = 0;
	int                failedTests = 0;
	int                sinceRefresh = 0;
	string             testName = "reset";
	logic              gated = 1'b0;            // rdEnable low, no reads expected
	sdramCmd_e         initCmds [$];
	dataWord_t         refImg [0:(1<<ADDR_W)-1];

	assign pinCmd = sdramCmd_e'({rasN, casN, weN});

	sdramCtrlTop i_dut (
		.REF_CLK(REF_CLK), .RESET_N(RESET_N),
		.wrPush(wrPush), .wrData(wrData), .wrFull(wrFull), .wrEmpty(wrEmpty),
		.wrLoad(wrLoad), .wrMinAddr(wrMinAddr), .wrMaxAddr(wrMaxAddr),
		.rdPop(rdPop), .rdData(rdData), .rdEmpty(rdEmpty),
		.rdLoad(rdLoad), .rdMinAddr(rdMinAddr), .rdMaxAddr(rdMaxAddr),
		.rdEnable(rdEnable), .initDone(initDone),
		.sdramAddr(sdramAddr), .sdramBank(sdramBank), .csN(csN), .rasN(rasN),
		.casN(casN), .weN(weN), .cke(cke), .dqm(dqm), .dq(dq)
	);

	sdramModel iModel (
		.REF_CLK(REF_CLK), .csN(csN), .rasN(rasN), .casN(casN), .weN(weN),
		.sdramAddr(sdramAddr), .sdramBank(sdramBank), .dq(dq)
	);

	initial REF_CLK = 1'b0;
	always #2 REF_CLK = ~REF_CLK;   // 4 ns period

	// ----------------------------------------------------------
	// Pin monitor
	always @(posedge REF_CLK)
	begin
		if (RESET_N)
		begin
			if (!initDone)
			begin
				if (pinCmd != CMD_NOP)
				begin
					initCmds.push_back(pinCmd);
				end
				if (pinCmd == CMD_ACTIVE)
				begin
					$display("ACTIVE command issued before initDone");
					errorCount++;
				end
			end
			else
			begin
				sinceRefresh = (pinCmd == CMD_REFRESH) ? 0 : sinceRefresh + 1;
				if (sinceRefresh > REF_LIMIT)
				begin
					$display("no REFRESH command for %0d cycles", REF_LIMIT);
					errorCount++;
					sinceRefresh = 0;
				end
			end
			if (cke !== 1'b1 || csN !== 1'b0 || dqm !== '0)
			begin
				$display("cke, csN or dqm off its fixed level in test %s", testName);
				errorCount++;
			end
			if (gated && pinCmd == CMD_READ)
			begin
				$display("READ command issued while rdEnable low in test %s", testName);
				errorCount++;
			end
			if (gated && !rdEmpty)
			begin
				$display("read FIFO not empty while rdEnable low in test %s", testName);
				errorCount++;
			end
		end
	end

	task automatic checkWord(input string what, input dataWord_t exp, input dataWord_t act);
		if (exp !== act)
		begin
			$display("mismatch %s: expected %h actual %h", what, exp, act);
			errorCount++;
		end
	endtask

	task automatic checkCmd(input string what, input sdramCmd_e exp, input sdramCmd_e act);
		if (exp !== act)
		begin
			$display("mismatch %s: expected %s actual %s", what, exp.name(), act.name());
			errorCount++;
		end
	endtask

	task automatic failTimeout(input string what);
		$display("timeout waiting for %s in test %s", what, testName);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic nextCycle;
		@(posedge REF_CLK);
		#1;                       // Drive after the edge
	endtask

	// Burst step or back to window start
	function automatic memAddr_t advance(input memAddr_t p, input memAddr_t lo, input memAddr_t hi);
		return (p < hi - memAddr_t'(BURST_LEN)) ? p + memAddr_t'(BURST_LEN) : lo;
	endfunction

	task automatic waitQuiet;
		int quiet;
		int n;
		quiet = 0;
		n     = 0;
		while (quiet < QUIET_CYCLES)
		begin
			nextCycle();
			if (pinCmd == CMD_ACTIVE || pinCmd == CMD_READ || pinCmd == CMD_WRITE)
				quiet = 0;
			else
				quiet++;
			n++;
			if (n > WAIT_LIMIT)
				failTimeout("idle SDRAM bus");
		end
	endtask

	task automatic loadWindows(input memAddr_t lo, input memAddr_t hi);
		wrMinAddr = lo;
		wrMaxAddr = hi;
		rdMinAddr = lo;
		rdMaxAddr = hi;
		wrLoad    = 1'b1;
		rdLoad    = 1'b1;
		nextCycle();
		wrLoad    = 1'b0;
		rdLoad    = 1'b0;
	endtask

	task automatic pushWord(input dataWord_t d);
		int n;
		n = 0;
		while (wrFull)
		begin
			nextCycle();
			n++;
			if (n > WAIT_LIMIT)
				failTimeout("write FIFO space");
		end
		wrPush = 1'b1;
		wrData = d;
		nextCycle();
		wrPush = 1'b0;
	endtask

	task automatic popWord(input dataWord_t exp);
		int n;
		int gap;
		n = 0;
		while (rdEmpty)
		begin
			nextCycle();
			n++;
			if (n > WAIT_LIMIT)
				failTimeout("read data");
		end
		checkWord(testName, exp, rdData);
		rdPop = 1'b1;
		nextCycle();
		rdPop = 1'b0;
		gap   = $unsigned($random(seed)) % 4;   // Random pop spacing
		repeat (gap) nextCycle();
	endtask

	// ----------------------------------------------------------
	// One line of test data
	task automatic runTest(input string name, input memAddr_t lo, input memAddr_t hi,
		input int count, input dataWord_t first);
		memAddr_t ptr;
		int       errBefore;
		int       n;
		testName  = name;
		errBefore = errorCount;
		waitQuiet();
		if (name.substr(0, 3) == "load")
		begin
			loadWindows(hi, hi + 64);            // Partial burst, later flushed
			for (int i = 0; i < 5; i++)
				pushWord(16'hdead ^ dataWord_t'(i));
		end
		loadWindows(lo, hi);
		gated = 1'b1;
		ptr = lo;
		for (int i = 0; i < count; i++)
		begin
			refImg[ptr + memAddr_t'(i % BURST_LEN)] = dataWord_t'(first + i);
			if (i % BURST_LEN == BURST_LEN - 1)
				ptr = advance(ptr, lo, hi);
		end
		for (int i = 0; i < count; i++)
			pushWord(dataWord_t'(first + i));
		n = 0;
		while (!wrEmpty)
		begin
			nextCycle();
			n++;
			if (n > WAIT_LIMIT)
				failTimeout("write FIFO drain");
		end
		gated    = 1'b0;
		rdEnable = 1'b1;
		ptr = lo;
		for (int i = 0; i < count; i++)
		begin
			popWord(refImg[ptr + memAddr_t'(i % BURST_LEN)]);
			if (i % BURST_LEN == BURST_LEN - 1)
				ptr = advance(ptr, lo, hi);
		end
		rdEnable = 1'b0;
		testCount++;
		if (errorCount == errBefore)
			$display("test %s passed", name);
		else
		begin
			$display("test %s failed with %0d errors", name, errorCount - errBefore);
			failedTests++;
		end
	endtask

	initial
	begin
		int        fd;
		int        n;
		int        errBefore;
		string     line;
		string     name;
		memAddr_t  lo;
		memAddr_t  hi;
		int        count;
		dataWord_t first;
		sdramCmd_e initExp [4];
		RESET_N   = 1'b0;
		wrPush    = 1'b0;
		wrData    = '0;
		wrLoad    = 1'b0;
		wrMinAddr = '0;
		wrMaxAddr = '0;
		rdPop     = 1'b0;
		rdLoad    = 1'b0;
		rdMinAddr = '0;
		rdMaxAddr = '0;
		rdEnable  = 1'b0;
		initExp   = '{CMD_PRECHARGE, CMD_REFRESH, CMD_REFRESH, CMD_LOAD_MODE};
		repeat (4) @(posedge REF_CLK);
		#1 RESET_N = 1'b1;

		// ----------------------------------------------------------
		// Power-up sequence
		testName = "init";
		for (int i = 0; i < BURST_LEN; i++)
			pushWord(dataWord_t'(16'h0f00 + i));   // Full burst waiting on init
		n = 0;
		while (!initDone)
		begin
			nextCycle();
			n++;
			if (n > WAIT_LIMIT)
				failTimeout("initDone");
		end
		testCount++;
		if (initCmds.size() != 4)
		begin
			$display("init issued %0d commands instead of 4", initCmds.size());
			errorCount++;
		end
		else
			for (int i = 0; i < 4; i++)
				checkCmd("init", initExp[i], initCmds[i]);
		if (errorCount == 0)
			$display("test init passed");
		else
		begin
			$display("test init failed with %0d errors", errorCount);
			failedTests++;
		end

		fd = $fopen("dv/sdramCtrl_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the test data file");
			errorCount++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#")
				begin
					if ($sscanf(line, "%s %h %h %d %h", name, lo, hi, count, first) == 5)
						runTest(name, lo, hi, count, first);
				end
			end
			$fclose(fd);
		end

		testName  = "idle";
		errBefore = errorCount;
		repeat (3 * REFRESH_INTERVAL) nextCycle();   // Refresh keeps running when idle
		testCount++;
		if (errorCount == errBefore)
			$display("test idle passed");
		else
		begin
			$display("test idle failed with %0d errors", errorCount - errBefore);
			failedTests++;
		end

		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/sdramCtrl_testdata.txt ====
# name  minAddr  maxAddr  wordCount  firstValue
# addresses and first value in hex, word count in decimal, a multiple of 8
round_small   000000 000040 32 1000
round_bank    123400 123480 64 2000
wrap_short    000100 000120 64 3000
load_restart  000200 000240 40 4000
wrap_odd      3ff000 3ff018 48 5000
round_large   0a0000 0a0100 96 6000

// ==== dv/sdramModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdramModel import sdramGeomPkg::*, sdramCmdPkg::*;
(
	input  logic              REF_CLK,
	input  logic              csN,
	input  logic              rasN,
	input  logic              casN,
	input  logic              weN,
	input  pinAddr_t          sdramAddr,
	input  logic [BANK_W-1:0] sdramBank,
	inout  wire dataWord_t    dq
);

	dataWord_t         mem [0:(1<<ADDR_W)-1];
	pinAddr_t          openRow [1<<BANK_W];   // Row latched by ACTIVE
	sdramCmd_e         pinCmd;
	dataWord_t         dqOut;
	logic              dqOe = 1'b0;
	logic [BANK_W-1:0] wrBank;
	pinAddr_t          wrRow;
	logic [COL_W-1:0]  wrCol;
	int                wrIdx  = 0;
	int                wrLeft = 0;            // Write beats still to take
	logic [BANK_W-1:0] rdBank;
	pinAddr_t          rdRow;
	logic [COL_W-1:0]  rdCol;
	int                rdIdx  = 0;
	int                rdLeft = 0;            // Read beats still to drive
	int                rdWait = 0;

	assign pinCmd = csN ? CMD_NOP : sdramCmd_e'({rasN, casN, weN});
	assign dq     = dqOe ? dqOut : 'z;

	// Sequential burst wraps inside an aligned group of BURST_LEN
	function automatic memAddr_t wordAddr(input logic [BANK_W-1:0] b, input pinAddr_t r,
		input logic [COL_W-1:0] c, input int idx);
		logic [COL_W-1:0] col;
		col = (c & ~COL_W'(BURST_LEN - 1)) | ((c + COL_W'(idx)) & COL_W'(BURST_LEN - 1));
		return {b, r, col};
	endfunction

	always @(posedge REF_CLK)
	begin
		// ----------------------------------------------------------
		// Beats of bursts already running
		if (wrLeft != 0)
		begin
			mem[wordAddr(wrBank, wrRow, wrCol, wrIdx)] = dq;
			wrIdx++;
			wrLeft--;
		end
		if (rdLeft != 0 && rdWait == 0)
		begin
			dqOut <= mem[wordAddr(rdBank, rdRow, rdCol, rdIdx)];
			dqOe  <= 1'b1;
			rdIdx++;
			rdLeft--;
		end
		else if (rdLeft == 0)
		begin
			dqOe <= 1'b0;                    // Release bus after last word
		end
		if (rdWait != 0)
		begin
			rdWait--;
		end

		// ----------------------------------------------------------
		// New commands
		case (pinCmd)
			CMD_ACTIVE: openRow[sdramBank] = sdramAddr;
			CMD_WRITE:
			begin
				wrBank = sdramBank;
				wrRow  = openRow[sdramBank];
				wrCol  = sdramAddr[COL_W-1:0];
				mem[wordAddr(wrBank, wrRow, wrCol, 0)] = dq;   // First word with command
				wrIdx  = 1;
				wrLeft = BURST_LEN - 1;
			end
			CMD_READ:
			begin
				rdBank = sdramBank;
				rdRow  = openRow[sdramBank];
				rdCol  = sdramAddr[COL_W-1:0];
				rdIdx  = 0;
				rdLeft = BURST_LEN;
				rdWait = CAS_LAT - 2;        // Driven one edge early, sampled at CAS
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/burstArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstArbiter import sdramGeomPkg::*, sdramCmdPkg::*;
(
	input  logic               REF_CLK,
	input  logic               RESET_N,
	input  logic               initDone,
	input  logic               wrLoad,      // Latch write window, restart pointer
	input  memAddr_t           wrMinAddr,
	input  memAddr_t           wrMaxAddr,
	input  logic               rdLoad,      // Latch read window, restart pointer
	input  memAddr_t           rdMinAddr,
	input  memAddr_t           rdMaxAddr,
	input  logic               rdEnable,
	input  logic [LEVEL_W-1:0] wrLevel,
	input  logic [LEVEL_W-1:0] rdLevel,
	output logic               burstReq,
	output logic               burstWrite,
	output memAddr_t           burstAddr,
	input  logic               burstAck,
	input  logic               burstDone
);

	arbState_e state;
	memAddr_t  wrMin;
	memAddr_t  wrMax;
	memAddr_t  wrPtr;
	memAddr_t  rdMin;
	memAddr_t  rdMax;
	memAddr_t  rdPtr;
	memAddr_t  wrNext;
	memAddr_t  rdNext;
	logic      reloaded;   // Stream in flight got a load pulse
	logic      wrGo;
	logic      rdGo;

	// Write needs a full burst waiting, read needs room for one
	assign wrGo = initDone && (wrLevel >= BURST_LEVEL) && !wrLoad;
	assign rdGo = initDone && rdEnable && (rdLevel <= RD_LEVEL_MAX) && !rdLoad;

	// Step one burst, or back to window start when the next one won't fit
	assign wrNext = (wrPtr < wrMax - BURST_STEP) ? wrPtr + BURST_STEP : wrMin;
	assign rdNext = (rdPtr < rdMax - BURST_STEP) ? rdPtr + BURST_STEP : rdMin;

	// ----------------------------------------------------------
	// Windows and stream pointers
	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrMin    <= '0;
			wrMax    <= '0;
			wrPtr    <= '0;
			rdMin    <= '0;
			rdMax    <= '0;
			rdPtr    <= '0;
			reloaded <= 1'b0;
		end
		else
		begin
			if (wrLoad)
			begin
				wrMin <= wrMinAddr;
				wrMax <= wrMaxAddr;
				wrPtr <= wrMinAddr;
			end
			else if (burstDone && state == ARB_WRITE_BURST && !reloaded)
			begin
				wrPtr <= wrNext;
			end

			if (rdLoad)
			begin
				rdMin <= rdMinAddr;
				rdMax <= rdMaxAddr;
				rdPtr <= rdMinAddr;
			end
			else if (burstDone && state == ARB_READ_BURST && !reloaded)
			begin
				rdPtr <= rdNext;
			end

			// A reload mid burst keeps the fresh pointer at its minimum
			if (state == ARB_IDLE)
			begin
				reloaded <= 1'b0;
			end
			else if ((state == ARB_WRITE_BURST && wrLoad) || (state == ARB_READ_BURST && rdLoad))
			begin
				reloaded <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Burst selection, writes first
	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state      <= ARB_IDLE;
			burstReq   <= 1'b0;
			burstWrite <= 1'b0;
			burstAddr  <= '0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					if (wrGo)
					begin
						burstReq   <= 1'b1;
						burstWrite <= 1'b1;
						burstAddr  <= wrPtr;
						state      <= ARB_WRITE_BURST;
					end
					else if (rdGo)
					begin
						burstReq   <= 1'b1;
						burstWrite <= 1'b0;
						burstAddr  <= rdPtr;
						state      <= ARB_READ_BURST;
					end
				end
				ARB_WRITE_BURST, ARB_READ_BURST:
				begin
					if (burstAck)
					begin
						burstReq <= 1'b0;    // Held until taken
					end
					if (burstDone)
					begin
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/burstFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstFifo import sdramGeomPkg::*;
(
	input  logic               REF_CLK,
	input  logic               RESET_N,
	input  logic               flush,    // Drop all contents
	input  logic               push,
	input  dataWord_t          pushData,
	input  logic               pop,
	output dataWord_t          popData,  // Head word, valid while not empty
	output logic [LEVEL_W-1:0] level,
	output logic               full,
	output logic               empty
);

	dataWord_t        mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic             doPush;
	logic             doPop;

	assign doPush  = push & ~full;   // Push into a full FIFO is lost
	assign doPop   = pop & ~empty;
	assign full    = (level == LEVEL_W'(FIFO_DEPTH));
	assign empty   = (level == '0);
	assign popData = mem[rdPtr];     // First word fall through

	always_ff @(posedge REF_CLK)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= pushData;
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else if (flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (doPush)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;    // Idle or both at once
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/burstSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module burstSequencer import sdramGeomPkg::*, sdramCmdPkg::*;
(
	input  logic              REF_CLK,
	input  logic              RESET_N,
	input  logic              burstReq,
	input  logic              burstWrite,
	input  memAddr_t          burstAddr,
	output logic              burstAck,      // Pulse with ACTIVE
	output logic              burstDone,     // Pulse at end of recovery
	output logic              initDone,
	output logic              wrPop,
	output logic              captureStart,  // Pulse with READ
	output sdramCmd_e         cmd,
	output pinAddr_t          pinAddr,
	output logic [BANK_W-1:0] bank,
	output logic              driveDq
);

	seqState_e            state;
	logic [SEQ_CNT_W-1:0] cnt;          // Cycles spent in current state
	logic [SEQ_CNT_W-1:0] accessLast;
	logic [REF_CNT_W-1:0] refTimer;
	logic                 refDue;
	logic                 secondRef;    // Init refresh two still to go
	logic                 isWrite;
	logic [COL_W-1:0]     colReg;
	pinAddr_t             colAddr;

	// Write ends with its data, read waits out CAS latency too
	assign accessLast = isWrite ? SEQ_CNT_W'(BURST_LEN - 1) : SEQ_CNT_W'(CAS_LAT + BURST_LEN - 1);
	assign colAddr    = pinAddr_t'(colReg) | AP_MASK;   // Auto precharge

	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state        <= SEQ_INIT_WAIT;
			cnt          <= '0;
			refTimer     <= '0;
			refDue       <= 1'b0;
			secondRef    <= 1'b0;
			isWrite      <= 1'b0;
			colReg       <= '0;
			burstAck     <= 1'b0;
			burstDone    <= 1'b0;
			initDone     <= 1'b0;
			wrPop        <= 1'b0;
			captureStart <= 1'b0;
			cmd          <= CMD_NOP;
			pinAddr      <= '0;
			bank         <= '0;
			driveDq      <= 1'b0;
		end
		else
		begin
			cmd          <= CMD_NOP;   // Strobes last one cycle
			burstAck     <= 1'b0;
			burstDone    <= 1'b0;
			captureStart <= 1'b0;
			cnt          <= cnt + 1'b1;

			case (state)
				// --------------------------------------------------
				// Power-up sequence
				SEQ_INIT_WAIT:
				begin
					if (cnt == SEQ_CNT_W'(INIT_WAIT - 1))
					begin
						cmd     <= CMD_PRECHARGE;
						pinAddr <= AP_MASK;          // All banks
						cnt     <= '0;
						state   <= SEQ_INIT_PRE;
					end
				end
				SEQ_INIT_PRE:
				begin
					if (cnt == SEQ_CNT_W'(T_RP - 1))
					begin
						cmd   <= CMD_REFRESH;
						cnt   <= '0;
						state <= SEQ_INIT_REF;
					end
				end
				SEQ_INIT_REF:
				begin
					if (cnt == SEQ_CNT_W'(T_RFC - 1))
					begin
						cnt <= '0;
						if (!secondRef)
						begin
							cmd       <= CMD_REFRESH;
							secondRef <= 1'b1;
						end
						else
						begin
							cmd     <= CMD_LOAD_MODE;
							pinAddr <= MODE_WORD;
							bank    <= '0;
							state   <= SEQ_INIT_MODE;
						end
					end
				end
				SEQ_INIT_MODE:
				begin
					if (cnt == SEQ_CNT_W'(T_MRD - 1))
					begin
						initDone <= 1'b1;
						state    <= SEQ_IDLE;
					end
				end
				// --------------------------------------------------
				// Normal operation, refresh before the next burst
				SEQ_IDLE:
				begin
					cnt <= '0;
					if (refDue)
					begin
						cmd    <= CMD_REFRESH;
						refDue <= 1'b0;
						state  <= SEQ_REFRESH;
					end
					else if (burstReq)
					begin
						cmd      <= CMD_ACTIVE;
						burstAck <= 1'b1;
						bank     <= burstAddr[ADDR_W-1 -: BANK_W];
						pinAddr  <= burstAddr[COL_W +: ROW_W];    // Row
						colReg   <= burstAddr[COL_W-1:0];
						isWrite  <= burstWrite;
						state    <= SEQ_ACTIVATE;
					end
				end
				SEQ_REFRESH:
				begin
					if (cnt == SEQ_CNT_W'(T_RFC - 1))
					begin
						state <= SEQ_IDLE;
					end
				end
				SEQ_ACTIVATE:
				begin
					if (cnt == SEQ_CNT_W'(T_RCD - 1))
					begin
						cmd          <= isWrite ? CMD_WRITE : CMD_READ;
						pinAddr      <= colAddr;
						wrPop        <= isWrite;     // First word leaves with WRITE
						driveDq      <= isWrite;
						captureStart <= !isWrite;
						cnt          <= '0;
						state        <= SEQ_ACCESS;
					end
				end
				SEQ_ACCESS:
				begin
					if (cnt == accessLast)
					begin
						wrPop   <= 1'b0;
						driveDq <= 1'b0;
						cnt     <= '0;
						state   <= SEQ_RECOVER;
					end
				end
				SEQ_RECOVER:
				begin
					if (cnt == SEQ_CNT_W'(T_RP - 1))
					begin
						burstDone <= 1'b1;
						state     <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_INIT_WAIT;
			endcase

			// Refresh timer, set wins over the clear in IDLE
			if (initDone)
			begin
				if (refTimer == REF_CNT_W'(REFRESH_INTERVAL - 1))
				begin
					refTimer <= '0;
					refDue   <= 1'b1;
				end
				else
				begin
					refTimer <= refTimer + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sdramCmdPkg.sv ====
`default_nettype none

package sdramCmdPkg;

	// Pin code {rasN, casN, weN}, csN low
	typedef enum logic [2:0] {
		CMD_LOAD_MODE = 3'b000,
		CMD_REFRESH   = 3'b001,
		CMD_PRECHARGE = 3'b010,
		CMD_ACTIVE    = 3'b011,
		CMD_WRITE     = 3'b100,
		CMD_READ      = 3'b101,
		CMD_NOP       = 3'b111
	} sdramCmd_e;

	// Sequencer, init steps first
	typedef enum logic [3:0] {
		SEQ_INIT_WAIT,
		SEQ_INIT_PRE,
		SEQ_INIT_REF,
		SEQ_INIT_MODE,
		SEQ_IDLE,
		SEQ_REFRESH,
		SEQ_ACTIVATE,
		SEQ_ACCESS,
		SEQ_RECOVER
	} seqState_e;

	// Burst arbiter
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WRITE_BURST,
		ARB_READ_BURST
	} arbState_e;

endpackage

`default_nettype wire

// ==== rtl/sdramCtrlTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdramCtrlTop import sdramGeomPkg::*, sdramCmdPkg::*;
(
	input  logic              REF_CLK,
	input  logic              RESET_N,
	// Write stream
	input  logic              wrPush,
	input  dataWord_t         wrData,
	output logic              wrFull,
	output logic              wrEmpty,
	input  logic              wrLoad,
	input  memAddr_t          wrMinAddr,
	input  memAddr_t          wrMaxAddr,
	// Read stream
	input  logic              rdPop,
	output dataWord_t         rdData,
	output logic              rdEmpty,
	input  logic              rdLoad,
	input  memAddr_t          rdMinAddr,
	input  memAddr_t          rdMaxAddr,
	input  logic              rdEnable,
	output logic              initDone,
	// SDRAM pins
	output pinAddr_t          sdramAddr,
	output logic [BANK_W-1:0] sdramBank,
	output logic              csN,
	output logic              rasN,
	output logic              casN,
	output logic              weN,
	output logic              cke,
	output logic [DQM_W-1:0]  dqm,
	inout  wire dataWord_t    dq
);

	logic [LEVEL_W-1:0] wrLevel;
	logic [LEVEL_W-1:0] rdLevel;
	logic               wrPop;
	dataWord_t          wrWord;
	logic               rdPush;
	dataWord_t          rdWord;
	logic               burstReq;
	logic               burstWrite;
	memAddr_t           burstAddr;
	logic               burstAck;
	logic               burstDone;
	logic               captureStart;
	sdramCmd_e          seqCmd;
	pinAddr_t           pinAddr;
	logic [BANK_W-1:0]  bank;
	logic               driveDq;

	// ----------------------------------------------------------
	// Stream FIFOs, load pulse flushes
	burstFifo iWrFifo (
		.REF_CLK  (REF_CLK),
		.RESET_N  (RESET_N),
		.flush    (wrLoad),
		.push     (wrPush),
		.pushData (wrData),
		.pop      (wrPop),
		.popData  (wrWord),
		.level    (wrLevel),
		.full     (wrFull),
		.empty    (wrEmpty)
	);

	burstFifo iRdFifo (
		.REF_CLK  (REF_CLK),
		.RESET_N  (RESET_N),
		.flush    (rdLoad),
		.push     (rdPush),
		.pushData (rdWord),
		.pop      (rdPop),
		.popData  (rdData),
		.level    (rdLevel),
		.full     (),          // Arbiter keeps room for every burst
		.empty    (rdEmpty)
	);

	// ----------------------------------------------------------
	// Arbiter, sequencer, pins
	burstArbiter iArbiter (
		.REF_CLK    (REF_CLK),
		.RESET_N    (RESET_N),
		.initDone   (initDone),
		.wrLoad     (wrLoad),
		.wrMinAddr  (wrMinAddr),
		.wrMaxAddr  (wrMaxAddr),
		.rdLoad     (rdLoad),
		.rdMinAddr  (rdMinAddr),
		.rdMaxAddr  (rdMaxAddr),
		.rdEnable   (rdEnable),
		.wrLevel    (wrLevel),
		.rdLevel    (rdLevel),
		.burstReq   (burstReq),
		.burstWrite (burstWrite),
		.burstAddr  (burstAddr),
		.burstAck   (burstAck),
		.burstDone  (burstDone)
	);

	burstSequencer iSequencer (
		.REF_CLK      (REF_CLK),
		.RESET_N      (RESET_N),
		.burstReq     (burstReq),
		.burstWrite   (burstWrite),
		.burstAddr    (burstAddr),
		.burstAck     (burstAck),
		.burstDone    (burstDone),
		.initDone     (initDone),
		.wrPop        (wrPop),
		.captureStart (captureStart),
		.cmd          (seqCmd),
		.pinAddr      (pinAddr),
		.bank         (bank),
		.driveDq      (driveDq)
	);

	sdramPinStage iPinStage (
		.REF_CLK      (REF_CLK),
		.RESET_N      (RESET_N),
		.cmd          (seqCmd),
		.pinAddr      (pinAddr),
		.bank         (bank),
		.driveDq      (driveDq),
		.wrWord       (wrWord),
		.captureStart (captureStart),
		.rdPush       (rdPush),
		.rdWord       (rdWord),
		.sdramAddr    (sdramAddr),
		.sdramBank    (sdramBank),
		.csN          (csN),
		.rasN         (rasN),
		.casN         (casN),
		.weN          (weN),
		.cke          (cke),
		.dqm          (dqm),
		.dq           (dq)
	);

endmodule

`default_nettype wire

// ==== rtl/sdramGeomPkg.sv ====
`default_nettype none

package sdramGeomPkg;

	// ----------------------------------------------------------
	// Geometry
	localparam int DATA_W = 16;                     // DQ width
	localparam int DQM_W  = DATA_W / 8;             // One mask bit per byte lane
	localparam int ROW_W  = 12;
	localparam int COL_W  = 8;
	localparam int BANK_W = 2;
	localparam int ADDR_W = BANK_W + ROW_W + COL_W; // Linear word address

	typedef logic [DATA_W-1:0] dataWord_t;
	typedef logic [ADDR_W-1:0] memAddr_t;           // {bank, row, column}
	typedef logic [ROW_W-1:0]  pinAddr_t;

	// Burst and FIFO sizing
	localparam int BURST_LEN   = 8;
	localparam int BURST_CNT_W = $clog2(BURST_LEN);
	localparam int FIFO_DEPTH  = 32;
	localparam int PTR_W       = $clog2(FIFO_DEPTH);
	localparam int LEVEL_W     = PTR_W + 1;          // Holds 0..FIFO_DEPTH

	localparam memAddr_t           BURST_STEP   = memAddr_t'(BURST_LEN);
	localparam logic [LEVEL_W-1:0] BURST_LEVEL  = LEVEL_W'(BURST_LEN);
	localparam logic [LEVEL_W-1:0] RD_LEVEL_MAX = LEVEL_W'(FIFO_DEPTH - BURST_LEN);

	// ----------------------------------------------------------
	// Timing, in REF_CLK cycles
	localparam int CAS_LAT          = 2;
	localparam int T_RCD            = 2;   // ACTIVE to READ/WRITE
	localparam int T_RP             = 2;
	localparam int T_RFC            = 6;
	localparam int T_MRD            = 2;   // Mode load to first command
	localparam int INIT_WAIT        = 100; // Short power-up idle for simulation
	localparam int REFRESH_INTERVAL = 390;
	localparam int SEQ_CNT_W        = 7;   // Wide enough for INIT_WAIT
	localparam int REF_CNT_W        = $clog2(REFRESH_INTERVAL);

	// Burst 8, sequential, CAS 2, burst writes
	localparam pinAddr_t MODE_WORD = 12'b00_0_00_010_0_011;

	// A10 selects auto precharge or all banks
	localparam int       AP_BIT  = 10;
	localparam pinAddr_t AP_MASK = pinAddr_t'(1 << AP_BIT);

endpackage

`default_nettype wire

// ==== rtl/sdramPinStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdramPinStage import sdramGeomPkg::*, sdramCmdPkg::*;
(
	input  logic              REF_CLK,
	input  logic              RESET_N,
	input  sdramCmd_e         cmd,
	input  pinAddr_t          pinAddr,
	input  logic [BANK_W-1:0] bank,
	input  logic              driveDq,
	input  dataWord_t         wrWord,
	input  logic              captureStart,
	output logic              rdPush,
	output dataWord_t         rdWord,
	output pinAddr_t          sdramAddr,
	output logic [BANK_W-1:0] sdramBank,
	output logic              csN,
	output logic              rasN,
	output logic              casN,
	output logic              weN,
	output logic              cke,
	output logic [DQM_W-1:0]  dqm,
	inout  wire dataWord_t    dq
);

	logic [CAS_LAT:0]       capDly;   // Pin stage plus CAS latency
	logic [BURST_CNT_W-1:0] capCnt;   // Words left after the first
	dataWord_t              dqOut;
	logic                   dqOe;

	assign dq = dqOe ? dqOut : 'z;

	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			sdramAddr          <= '0;
			sdramBank          <= '0;
			csN                <= 1'b0;
			{rasN, casN, weN}  <= CMD_NOP;
			cke                <= 1'b1;
			dqm                <= '0;
			dqOe               <= 1'b0;
			capDly             <= '0;
			capCnt             <= '0;
			rdPush             <= 1'b0;
		end
		else
		begin
			sdramAddr          <= pinAddr;
			sdramBank          <= bank;
			csN                <= 1'b0;      // Single chip, always selected
			{rasN, casN, weN}  <= cmd;
			cke                <= 1'b1;
			dqm                <= '0;        // No byte masking
			dqOe               <= driveDq;
			capDly             <= {capDly[CAS_LAT-1:0], captureStart};

			// Burst of pushes starts once the first word is on DQ
			if (capDly[CAS_LAT])
			begin
				rdPush <= 1'b1;
				capCnt <= BURST_CNT_W'(BURST_LEN - 1);
			end
			else if (capCnt != '0)
			begin
				rdPush <= 1'b1;
				capCnt <= capCnt - 1'b1;
			end
			else
			begin
				rdPush <= 1'b0;
			end
		end
	end

	// Data path, sampled every cycle
	always_ff @(posedge REF_CLK)
	begin
		dqOut  <= wrWord;
		rdWord <= dq;
	end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/sdramGeomPkg.sv
rtl/sdramCmdPkg.sv
rtl/burstFifo.sv
rtl/burstArbiter.sv
rtl/burstSequencer.sv
rtl/sdramPinStage.sv
rtl/sdramCtrlTop.sv
dv/sdramModel.sv
dv/sdramCtrlTb.sv
